//--- verilog/udp_conn_pkg.sv
// UDP connection shared definitions
`default_nettype none

package udp_conn_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_len_t;

    localparam int UDP_HDR_BYTES   = 8;
    localparam int TX_TTL          = 64;
    localparam int RX_FIFO_DEPTH   = 2048;
    localparam int TX_FIFO_DEPTH   = 2048;
    localparam int LEN_QUEUE_DEPTH = 16;

    // One byte beat of a valid/ready stream, user flags a bad frame
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

    typedef struct packed {
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
        udp_len_t length;
    } udp_rx_hdr_t;

    typedef struct packed {
        logic [7:0] ttl;
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        port_t      src_port;
        port_t      dst_port;
        udp_len_t   length;
    } udp_tx_hdr_t;

    typedef struct packed {
        ip_addr_t local_ip;
        port_t    rx_port;
        port_t    tx_src_port;
        port_t    tx_dst_port;
        ip_addr_t tx_dst_ip;
    } udp_cfg_t;

    // Literals carry a prefix since both machines share this scope
    typedef enum logic [1:0] {
        FLT_IDLE,
        FLT_PASS,
        FLT_DROP
    } filter_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_PAYLOAD
    } tx_state_t;

endpackage

`default_nettype wire

//--- verilog/udp_rx_port_filter.sv
// UDP receive port filter
`timescale 1ns/100ps
`default_nettype none

module udp_rx_port_filter import udp_conn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire port_t       rx_port,
    input  wire udp_rx_hdr_t hdr,
    input  wire logic        hdr_valid,
    output logic             hdr_ready,
    input  wire axis_beat_t  in_beat,
    input  wire logic        in_valid,
    output logic             in_ready,
    output axis_beat_t       fifo_beat,
    output logic             fifo_valid,
    input  wire logic        fifo_ready
);

    filter_state_t state;

    // Header only accepted between datagrams
    assign hdr_ready = (state == FLT_IDLE);

    always_comb begin
        fifo_beat  = in_beat;
        fifo_valid = 1'b0;
        in_ready   = 1'b0;
        case (state)
            FLT_PASS: begin
                fifo_valid = in_valid;
                in_ready   = fifo_ready;
            end
            FLT_DROP: begin
                in_ready = 1'b1;
            end
            default: begin
                in_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FLT_IDLE;
        end else begin
            case (state)
                FLT_IDLE: begin
                    if (hdr_valid) begin
                        state <= (hdr.dst_port == rx_port) ? FLT_PASS : FLT_DROP;
                    end
                end
                FLT_PASS, FLT_DROP: begin
                    if (in_valid && in_ready && in_beat.last) begin
                        state <= FLT_IDLE;
                    end
                end
                default: begin
                    state <= FLT_IDLE;
                end
            endcase
        end
    end

    // No second header until the current payload has ended
    hdr_once_per_datagram: assert property (
        @(posedge clk) disable iff (rst)
        (hdr_valid && hdr_ready) |=> !hdr_ready
    ) else $error("rx header accepted while payload pending");

    // Mid-datagram beats keep the header side closed
    hdr_ready_only_idle: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && in_ready && !in_beat.last) |=> !hdr_ready
    ) else $error("rx hdr_ready high outside IDLE");

endmodule

`default_nettype wire

//--- verilog/axis_byte_fifo.sv
// Byte stream FIFO
`timescale 1ns/100ps
`default_nettype none

module axis_byte_fifo import udp_conn_pkg::*; #(
    parameter int DEPTH = RX_FIFO_DEPTH
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire axis_beat_t in_beat,
    input  wire logic       in_valid,
    output logic            in_ready,
    output axis_beat_t      out_beat,
    output logic            out_valid,
    input  wire logic       out_ready
);

    axis_beat_t mem [DEPTH];

    // Pointers wrap naturally, DEPTH is a power of two
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_write;
    logic                     do_read;

    assign in_ready  = (count != ($clog2(DEPTH)+1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= ($clog2(DEPTH)+1)'(DEPTH)
    ) else $error("fifo count above depth");

endmodule

`default_nettype wire

//--- verilog/udp_tx_frame_fifo.sv
// UDP transmit frame FIFO
`timescale 1ns/100ps
`default_nettype none

module udp_tx_frame_fifo import udp_conn_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire axis_beat_t in_beat,
    input  wire logic       in_valid,
    output logic            in_ready,
    output axis_beat_t      out_beat,
    output logic            out_valid,
    input  wire logic       out_ready,
    output udp_len_t        frame_len,
    output logic            frame_len_valid
);

    axis_beat_t mem [TX_FIFO_DEPTH];
    udp_len_t   len_mem [LEN_QUEUE_DEPTH];

    // Extra top bit tells full from empty
    logic [$clog2(TX_FIFO_DEPTH):0]   wr_ptr;
    logic [$clog2(TX_FIFO_DEPTH):0]   wr_ptr_commit;
    logic [$clog2(TX_FIFO_DEPTH):0]   rd_ptr;
    logic [$clog2(TX_FIFO_DEPTH):0]   fill;
    logic                             full;
    logic                             overflow;
    udp_len_t                         byte_cnt;

    logic [$clog2(LEN_QUEUE_DEPTH)-1:0] len_wr;
    logic [$clog2(LEN_QUEUE_DEPTH)-1:0] len_rd;
    logic [$clog2(LEN_QUEUE_DEPTH):0]   len_cnt;

    logic accept;
    logic store;
    logic commit;
    logic pop;

    assign fill = wr_ptr - rd_ptr;
    assign full = fill[$clog2(TX_FIFO_DEPTH)];

    assign in_ready = (len_cnt != ($clog2(LEN_QUEUE_DEPTH)+1)'(LEN_QUEUE_DEPTH));
    assign accept   = in_valid && in_ready;
    // Once a frame overflowed its remaining beats are thrown away
    assign store    = accept && !full && !overflow;
    assign commit   = store && in_beat.last && !in_beat.user;

    // Only committed beats are visible to the reader
    assign out_valid = (wr_ptr_commit != rd_ptr);
    assign out_beat  = mem[rd_ptr[$clog2(TX_FIFO_DEPTH)-1:0]];
    assign pop       = out_valid && out_ready && out_beat.last;

    assign frame_len       = len_mem[len_rd];
    assign frame_len_valid = (len_cnt != '0);

    always_ff @(posedge clk) begin
        if (store) begin
            mem[wr_ptr[$clog2(TX_FIFO_DEPTH)-1:0]] <= in_beat;
        end
        if (commit) begin
            len_mem[len_wr] <= byte_cnt + udp_len_t'(UDP_HDR_BYTES + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            overflow      <= 1'b0;
            byte_cnt      <= '0;
        end else if (accept) begin
            if (in_beat.last) begin
                if (commit) begin
                    wr_ptr        <= wr_ptr + 1'b1;
                    wr_ptr_commit <= wr_ptr + 1'b1;
                end else begin
                    // Bad or overflowed frame, rewind to last commit
                    wr_ptr <= wr_ptr_commit;
                end
                overflow <= 1'b0;
                byte_cnt <= '0;
            end else if (store) begin
                wr_ptr   <= wr_ptr + 1'b1;
                byte_cnt <= byte_cnt + 1'b1;
            end else begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr  <= '0;
            len_wr  <= '0;
            len_rd  <= '0;
            len_cnt <= '0;
        end else begin
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (commit) begin
                len_wr <= len_wr + 1'b1;
            end
            if (pop) begin
                len_rd <= len_rd + 1'b1;
            end
            case ({commit, pop})
                2'b10:   len_cnt <= len_cnt + 1'b1;
                2'b01:   len_cnt <= len_cnt - 1'b1;
                default: len_cnt <= len_cnt;
            endcase
        end
    end

    // Every readable beat belongs to a frame whose length is queued
    data_has_length: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> frame_len_valid
    ) else $error("tx payload visible without queued length");

endmodule

`default_nettype wire

//--- verilog/udp_tx_header_gen.sv
// UDP transmit header generator
`timescale 1ns/100ps
`default_nettype none

module udp_tx_header_gen import udp_conn_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire udp_cfg_t   cfg,
    input  wire udp_len_t   frame_len,
    input  wire logic       frame_len_valid,
    input  wire axis_beat_t in_beat,
    input  wire logic       in_valid,
    output logic            in_ready,
    output udp_tx_hdr_t     hdr,
    output logic            hdr_valid,
    input  wire logic       hdr_ready,
    output axis_beat_t      out_beat,
    output logic            out_valid,
    input  wire logic       out_ready
);

    tx_state_t state;

    assign hdr_valid = (state == TX_HDR);

    // Payload only flows after its header went out
    assign out_beat  = in_beat;
    assign out_valid = in_valid && (state == TX_PAYLOAD);
    assign in_ready  = out_ready && (state == TX_PAYLOAD);

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && frame_len_valid) begin
            hdr.ttl      <= 8'(TX_TTL);
            hdr.src_ip   <= cfg.local_ip;
            hdr.dst_ip   <= cfg.tx_dst_ip;
            hdr.src_port <= cfg.tx_src_port;
            hdr.dst_port <= cfg.tx_dst_port;
            hdr.length   <= frame_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_len_valid) begin
                        state <= TX_HDR;
                    end
                end
                TX_HDR: begin
                    if (hdr_ready) begin
                        state <= TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    if (in_valid && out_ready && in_beat.last) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Next frame waits for its own header
    no_payload_before_hdr: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && out_ready && out_beat.last) |=> !out_valid
    ) else $error("tx payload outside PAYLOAD state");

    // Length of the pending header stays queued until its payload is read
    hdr_length_queued: assert property (
        @(posedge clk) disable iff (rst)
        hdr_valid |-> frame_len_valid
    ) else $error("tx header pending without queued frame");

endmodule

`default_nettype wire

//--- verilog/udp_connection.sv
// UDP connection top level
`timescale 1ns/100ps
`default_nettype none

module udp_connection import udp_conn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire udp_cfg_t    cfg,
    input  wire udp_rx_hdr_t rx_hdr,
    input  wire logic        rx_hdr_valid,
    output logic             rx_hdr_ready,
    input  wire axis_beat_t  rx_in,
    input  wire logic        rx_in_valid,
    output logic             rx_in_ready,
    output axis_beat_t       rx_out,
    output logic             rx_out_valid,
    input  wire logic        rx_out_ready,
    input  wire axis_beat_t  tx_in,
    input  wire logic        tx_in_valid,
    output logic             tx_in_ready,
    output udp_tx_hdr_t      tx_hdr,
    output logic             tx_hdr_valid,
    input  wire logic        tx_hdr_ready,
    output axis_beat_t       tx_out,
    output logic             tx_out_valid,
    input  wire logic        tx_out_ready
);

    // Filter to receive FIFO
    axis_beat_t rx_fifo_beat;
    logic       rx_fifo_valid;
    logic       rx_fifo_ready;

    // Frame FIFO to header generator
    axis_beat_t tx_fifo_beat;
    logic       tx_fifo_valid;
    logic       tx_fifo_ready;
    udp_len_t   tx_frame_len;
    logic       tx_frame_len_valid;

    udp_rx_port_filter udp_rx_port_filter_i (
        .clk        (clk),
        .rst        (rst),
        .rx_port    (cfg.rx_port),
        .hdr        (rx_hdr),
        .hdr_valid  (rx_hdr_valid),
        .hdr_ready  (rx_hdr_ready),
        .in_beat    (rx_in),
        .in_valid   (rx_in_valid),
        .in_ready   (rx_in_ready),
        .fifo_beat  (rx_fifo_beat),
        .fifo_valid (rx_fifo_valid),
        .fifo_ready (rx_fifo_ready)
    );

    axis_byte_fifo #(
        .DEPTH (RX_FIFO_DEPTH)
    ) rx_payload_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (rx_fifo_beat),
        .in_valid  (rx_fifo_valid),
        .in_ready  (rx_fifo_ready),
        .out_beat  (rx_out),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready)
    );

    udp_tx_frame_fifo udp_tx_frame_fifo_i (
        .clk             (clk),
        .rst             (rst),
        .in_beat         (tx_in),
        .in_valid        (tx_in_valid),
        .in_ready        (tx_in_ready),
        .out_beat        (tx_fifo_beat),
        .out_valid       (tx_fifo_valid),
        .out_ready       (tx_fifo_ready),
        .frame_len       (tx_frame_len),
        .frame_len_valid (tx_frame_len_valid)
    );

    udp_tx_header_gen udp_tx_header_gen_i (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .frame_len       (tx_frame_len),
        .frame_len_valid (tx_frame_len_valid),
        .in_beat         (tx_fifo_beat),
        .in_valid        (tx_fifo_valid),
        .in_ready        (tx_fifo_ready),
        .hdr             (tx_hdr),
        .hdr_valid       (tx_hdr_valid),
        .hdr_ready       (tx_hdr_ready),
        .out_beat        (tx_out),
        .out_valid       (tx_out_valid),
        .out_ready       (tx_out_ready)
    );

endmodule

`default_nettype wire

//--- testbench/udp_connection_tb.sv
// UDP connection testbench
`timescale 1ns/100ps
`default_nettype none

module udp_connection_tb import udp_conn_pkg::*; ();

    localparam int CLK_PERIOD       = 20;
    localparam int TOTAL_FRAMES     = 63;
    localparam int CYCLES_PER_FRAME = 200;
    localparam int MARGIN_CYCLES    = 2000;
    localparam int SETTLE_CYCLES    = 10;

    logic        clk;
    logic        rst;
    udp_cfg_t    cfg;
    udp_rx_hdr_t rx_hdr;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    axis_beat_t  rx_in;
    logic        rx_in_valid;
    logic        rx_in_ready;
    axis_beat_t  rx_out;
    logic        rx_out_valid;
    logic        rx_out_ready;
    axis_beat_t  tx_in;
    logic        tx_in_valid;
    logic        tx_in_ready;
    udp_tx_hdr_t tx_hdr;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    axis_beat_t  tx_out;
    logic        tx_out_valid;
    logic        tx_out_ready;

    // Reference queues and their heads as seen by the assertions
    axis_beat_t  rx_exp_q[$];
    axis_beat_t  tx_exp_q[$];
    udp_tx_hdr_t hdr_exp_q[$];
    axis_beat_t  tx_frame_q[$];
    axis_beat_t  rx_head;
    axis_beat_t  tx_head;
    udp_tx_hdr_t hdr_head;
    logic        rx_head_ok;
    logic        tx_head_ok;
    logic        hdr_head_ok;
    logic        rx_match;
    logic        random_ready;
    // Set between a header transfer and the tail of its payload
    logic        hdr_open;

    int error_count;
    int tests_run;
    int tests_failed;
    int test_err_start;

    udp_connection udp_connection_i (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_in        (rx_in),
        .rx_in_valid  (rx_in_valid),
        .rx_in_ready  (rx_in_ready),
        .rx_out       (rx_out),
        .rx_out_valid (rx_out_valid),
        .rx_out_ready (rx_out_ready),
        .tx_in        (tx_in),
        .tx_in_valid  (tx_in_valid),
        .tx_in_ready  (tx_in_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_out       (tx_out),
        .tx_out_valid (tx_out_valid),
        .tx_out_ready (tx_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Output ready patterns
    initial begin
        rx_out_ready = 1'b1;
        tx_hdr_ready = 1'b1;
        tx_out_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (random_ready) begin
                rx_out_ready <= 1'($urandom % 2);
                tx_hdr_ready <= 1'($urandom % 2);
                tx_out_ready <= 1'($urandom % 2);
            end else begin
                rx_out_ready <= 1'b1;
                tx_hdr_ready <= 1'b1;
                tx_out_ready <= 1'b1;
            end
        end
    end

    initial begin
        repeat (TOTAL_FRAMES * CYCLES_PER_FRAME + MARGIN_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not complete in the expected number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic flag_mismatch(input string msg);
        error_count++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    // Expected traffic follows from the accepted input transfers
    always @(posedge clk) begin
        udp_tx_hdr_t exp_hdr;
        if (!rst) begin
            if (rx_hdr_valid && rx_hdr_ready) begin
                rx_match = (rx_hdr.dst_port == cfg.rx_port);
            end
            if (rx_in_valid && rx_in_ready && rx_match) begin
                rx_exp_q.push_back(rx_in);
            end
            if (tx_in_valid && tx_in_ready) begin
                tx_frame_q.push_back(tx_in);
                if (tx_in.last) begin
                    if (!tx_in.user) begin
                        foreach (tx_frame_q[i]) begin
                            tx_exp_q.push_back(tx_frame_q[i]);
                        end
                        exp_hdr.ttl      = 8'd64;
                        exp_hdr.src_ip   = cfg.local_ip;
                        exp_hdr.dst_ip   = cfg.tx_dst_ip;
                        exp_hdr.src_port = cfg.tx_src_port;
                        exp_hdr.dst_port = cfg.tx_dst_port;
                        exp_hdr.length   = udp_len_t'(tx_frame_q.size() + 8);
                        hdr_exp_q.push_back(exp_hdr);
                    end
                    tx_frame_q.delete();
                end
            end
            if (tx_out_valid && tx_out_ready && tx_out.last) begin
                hdr_open <= 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                hdr_open <= 1'b1;
            end
            if (rx_out_valid && rx_out_ready && rx_exp_q.size() != 0) begin
                void'(rx_exp_q.pop_front());
            end
            if (tx_out_valid && tx_out_ready && tx_exp_q.size() != 0) begin
                void'(tx_exp_q.pop_front());
            end
            if (tx_hdr_valid && tx_hdr_ready && hdr_exp_q.size() != 0) begin
                void'(hdr_exp_q.pop_front());
            end
        end
    end

    // Heads settle mid-cycle, well before the next sampling edge
    always @(negedge clk) begin
        rx_head_ok  = (rx_exp_q.size() != 0);
        tx_head_ok  = (tx_exp_q.size() != 0);
        hdr_head_ok = (hdr_exp_q.size() != 0);
        rx_head     = rx_head_ok ? rx_exp_q[0] : '0;
        tx_head     = tx_head_ok ? tx_exp_q[0] : '0;
        hdr_head    = hdr_head_ok ? hdr_exp_q[0] : '0;
    end

    rx_out_expected: assert property (
        @(posedge clk) disable iff (rst)
        (rx_out_valid && rx_out_ready) |-> (rx_head_ok && rx_out == rx_head)
    ) else flag_mismatch("rx_out beat is not the next expected datagram byte");

    tx_hdr_expected: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && tx_hdr_ready) |-> (hdr_head_ok && tx_hdr == hdr_head)
    ) else flag_mismatch("tx_hdr is not the header of the next committed frame");

    tx_out_expected: assert property (
        @(posedge clk) disable iff (rst)
        (tx_out_valid && tx_out_ready) |-> (tx_head_ok && tx_out == tx_head)
    ) else flag_mismatch("tx_out beat is not the next expected frame byte");

    tx_out_after_hdr: assert property (
        @(posedge clk) disable iff (rst)
        (tx_out_valid && tx_out_ready) |-> hdr_open
    ) else flag_mismatch("tx_out beat sent before the header of its frame");

    function automatic int rand_len();
        return 1 + int'($urandom % 64);
    endfunction

    function automatic port_t other_port();
        port_t p;
        p = port_t'($urandom);
        while (p == cfg.rx_port) begin
            p = port_t'($urandom);
        end
        return p;
    endfunction

    task automatic send_rx(input port_t dst_port, input int len);
        udp_rx_hdr_t hdr;
        axis_beat_t  beat;
        hdr.src_ip   = ip_addr_t'($urandom);
        hdr.dst_ip   = cfg.local_ip;
        hdr.src_port = port_t'($urandom);
        hdr.dst_port = dst_port;
        hdr.length   = udp_len_t'(len + 8);
        rx_hdr       <= hdr;
        rx_hdr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < len; i++) begin
            beat.data   = byte_t'($urandom);
            beat.last   = (i == len - 1);
            beat.user   = 1'b0;
            rx_in       <= beat;
            rx_in_valid <= 1'b1;
            do begin
                @(posedge clk);
            end while (!rx_in_ready);
        end
        rx_in_valid <= 1'b0;
    endtask

    task automatic send_tx(input int len, input logic bad);
        axis_beat_t beat;
        for (int i = 0; i < len; i++) begin
            beat.data   = byte_t'($urandom);
            beat.last   = (i == len - 1);
            beat.user   = bad && (i == len - 1);
            tx_in       <= beat;
            tx_in_valid <= 1'b1;
            do begin
                @(posedge clk);
            end while (!tx_in_ready);
        end
        tx_in_valid <= 1'b0;
    endtask

    task automatic begin_test();
        test_err_start = error_count;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        while (rx_exp_q.size() != 0 || tx_exp_q.size() != 0 || hdr_exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        tests_run++;
        if (error_count == test_err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - test_err_start);
        end
    endtask

    initial begin
        void'($urandom(32'hcadb867e));
        error_count      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        test_err_start   = 0;
        rst              = 1'b1;
        random_ready     = 1'b0;
        rx_match         = 1'b0;
        hdr_open         = 1'b0;
        cfg.local_ip     = ip_addr_t'($urandom);
        cfg.rx_port      = port_t'($urandom);
        cfg.tx_src_port  = port_t'($urandom);
        cfg.tx_dst_port  = port_t'($urandom);
        cfg.tx_dst_ip    = ip_addr_t'($urandom);
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_in            = '0;
        rx_in_valid      = 1'b0;
        tx_in            = '0;
        tx_in_valid      = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        begin_test();
        send_rx(cfg.rx_port, rand_len());
        end_test("rx matching datagram");

        begin_test();
        repeat (4) send_rx(other_port(), rand_len());
        send_rx(cfg.rx_port, rand_len());
        end_test("rx other ports dropped");

        begin_test();
        random_ready <= 1'b1;
        repeat (24) begin
            if (($urandom % 2) == 0) begin
                send_rx(cfg.rx_port, rand_len());
            end else begin
                send_rx(other_port(), rand_len());
            end
        end
        end_test("rx mixed train with back-pressure");
        random_ready <= 1'b0;

        begin_test();
        repeat (6) send_tx(rand_len(), 1'b0);
        end_test("tx header and payload");

        begin_test();
        send_tx(rand_len(), 1'b0);
        send_tx(rand_len(), 1'b1);
        send_tx(rand_len(), 1'b0);
        end_test("tx bad frame dropped");

        begin_test();
        random_ready <= 1'b1;
        repeat (24) send_tx(rand_len(), ($urandom % 6) == 0);
        end_test("tx train with back-pressure");
        random_ready <= 1'b0;

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/udp_conn_pkg.sv
verilog/udp_rx_port_filter.sv
verilog/axis_byte_fifo.sv
verilog/udp_tx_frame_fifo.sv
verilog/udp_tx_header_gen.sv
verilog/udp_connection.sv
testbench/udp_connection_tb.sv

//--- Makefile
# Verilator build for the UDP connection testbench

TOP := udp_connection_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
